// File: sources.f
+incdir+source
source/vendingPkg.sv
source/keyDecode.sv
source/creditExecute.sv
source/bcdConvert.sv
source/displayResult.sv
source/vendingMachine.sv
verification/vendingProperties.sv
verification/vendingTb.sv

// File: verification/vendingTb.sv
`timescale 1ns/10ps
`include "vendingDefines.svh"

module vendingTb;
    import vendingPkg::*;

    localparam int CLOCK_NS     = 40;
    localparam int RESET_CYCLES = 16;
    localparam int SETTLE       = 64;  // cycles from release to checking
    localparam int PRESS_BUDGET = 170; // above the 145 presses of all tests
    localparam int WATCHDOG_NS  = (PRESS_BUDGET * 80 + RESET_CYCLES) * CLOCK_NS;

    localparam int ITEM_PRICE [9] = '{`PRICE_A1, `PRICE_A2, `PRICE_A3, `PRICE_B1, `PRICE_B2,
                                      `PRICE_B3, `PRICE_C1, `PRICE_C2, `PRICE_C3};
    localparam int COIN_VALUE [5] = '{`COIN_NICKEL, `COIN_DIME, `COIN_QUARTER,
                                      `COIN_DOLLAR, `COIN_FIVE};
    localparam segmentT SEG_TABLE [10] = '{`SEG_DIGIT_0, `SEG_DIGIT_1, `SEG_DIGIT_2,
                                           `SEG_DIGIT_3, `SEG_DIGIT_4, `SEG_DIGIT_5,
                                           `SEG_DIGIT_6, `SEG_DIGIT_7, `SEG_DIGIT_8,
                                           `SEG_DIGIT_9};

    logic       A1;
    logic       A2;
    itemMaskT   itemKey;
    coinMaskT   coinKey;
    logic       cancelKey;
    itemMaskT   greenLed;
    itemMaskT   redLed;
    itemMaskT   dispensedLed;
    logic [3:0] anode;
    segmentT    segment;

    int          credit;   // model state
    int          change;
    int          selected; // -1 while nothing bought
    int          showAmt;
    logic        showNeg;
    logic        showDec;
    logic [31:0] lfsr = 32'hcd7327a0;
    string       testName;
    int          errorCount;
    int          testCount;
    int          failedTests;
    int          testStartErrors;
    int          assertSeen; // bound checker failures already counted

    vendingMachine dut0 (
        .A1, .A2,
        .itemKey, .coinKey, .cancelKey,
        .greenLed, .redLed, .dispensedLed,
        .anode, .segment
    );

    always #(CLOCK_NS / 2) A1 = ~A1;

    function automatic logic nextBit();
        logic outBit;
        outBit = lfsr[0];
        lfsr   = lfsr >> 1;
        if (outBit) begin
            lfsr = lfsr ^ 32'h80200003; // x^32 + x^22 + x^2 + x + 1
        end
        return outBit;
    endfunction

    function automatic int randBits(input int count);
        int value;
        value = 0;
        for (int i = 0; i < count; i++) begin
            value = (value << 1) | int'(nextBit()); // one step per bit
        end
        return value;
    endfunction

    // expected segments of one position, 0 is the ones digit
    function automatic segmentT expectedSegment(input int pos);
        int      divisor;
        segmentT seg;
        divisor = (pos == 0) ? 1 : (pos == 1) ? 10 : (pos == 2) ? 100 : 1000;
        seg     = SEG_TABLE[(showAmt / divisor) % 10];
        if (pos == 3 && showNeg) begin
            seg = `SEG_DASH;
        end
        if (pos == 2 && showDec) begin
            seg = seg & `SEG_DP_MASK; // point between dollars and cents
        end
        return seg;
    endfunction

    task automatic applyModel(input itemMaskT items, input coinMaskT coins, input logic cancel);
        int coinIdx;
        int itemIdx;
        int price;
        coinIdx = -1;
        itemIdx = -1;
        for (int i = 4; i >= 0; i--) begin
            if (coins[i]) coinIdx = i; // lowest coin wins
        end
        for (int i = 8; i >= 0; i--) begin
            if (items[i]) itemIdx = i;
        end
        if (coinIdx >= 0) begin
            if (credit + COIN_VALUE[coinIdx] <= `MAX_CREDIT) begin // else refused, no change
                credit  = credit + COIN_VALUE[coinIdx];
                showAmt = credit;
                showNeg = 1'b0;
                showDec = 1'b1;
            end
        end else if (itemIdx >= 0) begin
            price   = ITEM_PRICE[itemIdx];
            showDec = 1'b1;
            if (credit == 0) begin
                showAmt = price;
                showNeg = 1'b0;
            end else if (credit >= price && price != 0) begin
                change   = credit - price; // credit itself stays
                selected = itemIdx;
                showAmt  = change;
                showNeg  = 1'b0;
            end else begin
                showAmt = (price == 0) ? 0 : price - credit;
                showNeg = 1'b1;
            end
        end else if (cancel) begin
            credit   = 0;
            change   = 0;
            selected = -1;
            showAmt  = 0;
            showNeg  = 1'b0;
            showDec  = 1'b0;
        end
    endtask

    task automatic press(input itemMaskT items, input coinMaskT coins, input logic cancel);
        applyModel(items, coins, cancel);
        @(negedge A1);
        itemKey   = items;
        coinKey   = coins;
        cancelKey = cancel;
        repeat (2) @(negedge A1);
        itemKey   = '0;
        coinKey   = '0;
        cancelKey = 1'b0;
        repeat (SETTLE) @(negedge A1);
    endtask

    task automatic pressCoin(input int idx);
        press('0, coinMaskT'(1) << idx, 1'b0);
    endtask

    task automatic pressItem(input int idx);
        press(itemMaskT'(1) << idx, '0, 1'b0);
    endtask

    task automatic pressCancel();
        press('0, '0, 1'b1);
    endtask

    task automatic reportMismatch(input string what, input logic [31:0] expected,
                                  input logic [31:0] actual);
        $display("MISMATCH %s %s: expected %0h, actual %0h", testName, what, expected, actual);
        errorCount++;
    endtask

    task automatic checkLeds();
        itemMaskT expGreen;
        itemMaskT expRed;
        itemMaskT expDisp;
        for (int i = 0; i < 9; i++) begin
            expGreen[i] = (credit >= ITEM_PRICE[i]) && (ITEM_PRICE[i] != 0);
            expRed[i]   = (ITEM_PRICE[i] == 0);
        end
        expDisp = (selected >= 0) ? itemMaskT'(1) << selected : '0;
        if (greenLed !== expGreen) reportMismatch("greenLed", expGreen, greenLed);
        if (redLed !== expRed) reportMismatch("redLed", expRed, redLed);
        if (dispensedLed !== expDisp) reportMismatch("dispensedLed", expDisp, dispensedLed);
    endtask

    // wait for each anode in turn and sample its segments
    task automatic checkDisplay();
        logic [3:0] want;
        int         waited;
        for (int pos = 0; pos < 4; pos++) begin
            want   = 4'b0001 << pos;
            want   = ~want;
            waited = 0;
            while (anode !== want && waited < 32) begin
                @(negedge A1);
                waited++;
            end
            if (waited >= 32) begin
                $display("ERROR %s: anode never selected digit %0d", testName, pos);
                errorCount++;
            end else if (segment !== expectedSegment(pos)) begin
                reportMismatch($sformatf("segment digit %0d", pos), expectedSegment(pos),
                               segment);
            end
        end
    endtask

    task automatic checkAll();
        checkLeds();
        checkDisplay();
    endtask

    // failures of the bound assertions count as errors of the running test
    task automatic collectAssertFails();
        int fresh;
        fresh = dut0.props0.failCount - assertSeen;
        if (fresh != 0) begin
            $display("ERROR %s: %0d bound assertion failures", testName, fresh);
            errorCount += fresh;
            assertSeen = dut0.props0.failCount;
        end
    endtask

    task automatic startTest(input string name);
        testName        = name;
        testStartErrors = errorCount;
    endtask

    task automatic endTest();
        collectAssertFails();
        testCount++;
        if (errorCount != testStartErrors) begin
            failedTests++;
            $display("test %s: failed with %0d errors", testName, errorCount - testStartErrors);
        end else begin
            $display("test %s: passed", testName);
        end
    endtask

    initial begin
        coinMaskT coins;
        itemMaskT items;
        int       coinCount;
        A1          = 1'b0;
        A2          = 1'b1;
        itemKey     = '0;
        coinKey     = '0;
        cancelKey   = 1'b0;
        credit      = 0;
        change      = 0;
        selected    = -1;
        showAmt     = 0;
        showNeg     = 1'b0;
        showDec     = 1'b0;
        errorCount  = 0;
        testCount   = 0;
        failedTests = 0;
        assertSeen  = 0;
        repeat (RESET_CYCLES) @(negedge A1);
        A2 = 1'b0;

        startTest("reset");
        repeat (4) @(negedge A1);
        checkAll();
        endTest();

        startTest("random coins");
        for (int n = 0; n < 40; n++) begin
            pressCoin(randBits(3) % 5); // small coins come more often
            checkAll();
        end
        endTest();

        startTest("price check");
        pressCancel();
        checkAll();
        for (int i = 0; i < 9; i++) begin
            pressItem(i);
            checkAll();
        end
        endTest();

        startTest("purchase and shortfall");
        for (int r = 0; r < 12; r++) begin
            pressCancel();
            coinCount = 1 + randBits(2);
            for (int c = 0; c < coinCount; c++) begin
                pressCoin(randBits(3) % 5);
            end
            pressItem(randBits(4) % 9);
            checkAll();
        end
        pressItem(1); // sold out with credit left from the last round
        checkAll();
        endTest();

        startTest("cancel");
        pressCancel();
        checkAll();
        pressItem(randBits(4) % 9);
        checkAll();
        endTest();

        startTest("simultaneous keys");
        for (int n = 0; n < 20; n++) begin
            coins = (randBits(2) == 0) ? coinMaskT'(randBits(5)) : '0;
            items = nextBit() ? itemMaskT'(randBits(9)) : '0;
            press(items, coins, nextBit());
            checkAll();
        end
        endTest();

        $display("tests: %0d run, %0d failed, %0d errors", testCount, failedTests, errorCount);
        if (errorCount == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("ERROR: run did not finish within %0d ns, stopped by watchdog", WATCHDOG_NS);
        $display("RESULT: FAIL");
        $finish;
    end

endmodule

// File: verification/vendingProperties.sv
`timescale 1ns/10ps

module vendingProperties (
    input logic                 A1,           // clock
    input logic                 A2,           // async reset, active high
    input logic [3:0]           anode,
    input vendingPkg::itemMaskT greenLed,
    input vendingPkg::itemMaskT redLed,
    input vendingPkg::itemMaskT dispensedLed
);

    int failCount = 0; // failed assertions so far

    // exactly one digit lit at any time
    anodeOneDigit: assert property (@(posedge A1) disable iff (A2) $onehot(~anode))
        else begin
            $error("anode selects %b, not exactly one digit", anode);
            failCount++;
        end

    // at most the last bought item
    dispensedSingle: assert property (@(posedge A1) disable iff (A2) $onehot0(dispensedLed))
        else begin
            $error("dispensedLed %b has more than one item lit", dispensedLed);
            failCount++;
        end

    // sold out and affordable exclude each other
    greenRedApart: assert property (@(posedge A1) disable iff (A2) (greenLed & redLed) == '0)
        else begin
            $error("greenLed %b and redLed %b overlap", greenLed, redLed);
            failCount++;
        end

endmodule

bind vendingMachine vendingProperties props0 (
    .A1, .A2, .anode, .greenLed, .redLed, .dispensedLed
);

// File: source/vendingMachine.sv
`timescale 1ns/10ps

module vendingMachine (
    input  logic                 A1,           // clock
    input  logic                 A2,           // async reset, active high
    input  vendingPkg::itemMaskT itemKey,      // A1..C3 item keys
    input  vendingPkg::coinMaskT coinKey,      // nickel..five
    input  logic                 cancelKey,
    output vendingPkg::itemMaskT greenLed,     // affordable
    output vendingPkg::itemMaskT redLed,       // sold out
    output vendingPkg::itemMaskT dispensedLed, // last item bought
    output logic [3:0]           anode,        // active low digit select
    output vendingPkg::segmentT  segment
);
    import vendingPkg::*;

    logic      cmdValid;
    cmdKindE   cmdKind;
    centsT     cmdCents;
    itemIndexT cmdItem;

    logic      showStrobe;
    centsT     showCents;
    logic      showNegative;
    logic      showDecimal;

    keyDecode keys0 (
        .A1, .A2,
        .itemKey, .coinKey, .cancelKey,
        .cmdValid, .cmdKind, .cmdCents, .cmdItem
    );

    creditExecute credit0 (
        .A1, .A2,
        .cmdValid, .cmdKind, .cmdCents, .cmdItem,
        .greenLed, .redLed, .dispensedLed,
        .showStrobe, .showCents, .showNegative, .showDecimal
    );

    displayResult display0 (
        .A1, .A2,
        .showStrobe, .showCents, .showNegative, .showDecimal,
        .anode, .segment
    );

endmodule

// File: source/displayResult.sv
`timescale 1ns/10ps
`include "vendingDefines.svh"

module displayResult (
    input  logic                A1,           // clock
    input  logic                A2,           // async reset, active high
    input  logic                showStrobe,
    input  vendingPkg::centsT   showCents,
    input  logic                showNegative,
    input  logic                showDecimal,
    output logic [3:0]          anode,        // active low, digit 0 rightmost
    output vendingPkg::segmentT segment
);
    import vendingPkg::*;

    logic                  startConv;
    centsT                 binValue;
    logic                  convDone;
    bcdDigitT              conv0;
    bcdDigitT              conv1;
    bcdDigitT              conv2;
    bcdDigitT              conv3;
    bcdDigitT              shown [4];    // digits on the display
    logic                  pendNegative; // flags wait for their digits
    logic                  pendDecimal;
    logic                  negHeld;
    logic                  decHeld;
    logic [`SCAN_BITS+1:0] scanCount;
    logic [1:0]            scanSel;

    function automatic segmentT digitToSeg(input bcdDigitT d);
        case (d)
            4'd0:    return `SEG_DIGIT_0;
            4'd1:    return `SEG_DIGIT_1;
            4'd2:    return `SEG_DIGIT_2;
            4'd3:    return `SEG_DIGIT_3;
            4'd4:    return `SEG_DIGIT_4;
            4'd5:    return `SEG_DIGIT_5;
            4'd6:    return `SEG_DIGIT_6;
            4'd7:    return `SEG_DIGIT_7;
            4'd8:    return `SEG_DIGIT_8;
            4'd9:    return `SEG_DIGIT_9;
            default: return `SEG_DASH; // not a decimal digit
        endcase
    endfunction

    assign startConv = showStrobe;
    assign binValue  = showCents;

    bcdConvert convert0 (
        .A1, .A2,
        .startConv, .binValue,
        .convDone,
        .digit0 (conv0),
        .digit1 (conv1),
        .digit2 (conv2),
        .digit3 (conv3)
    );

    always_ff @(posedge A1 or posedge A2) begin
        if (A2) begin
            shown        <= '{default: '0}; // 0000 after reset
            pendNegative <= 1'b0;
            pendDecimal  <= 1'b0;
            negHeld      <= 1'b0;
            decHeld      <= 1'b0;
            scanCount    <= '0;
        end else begin
            scanCount <= scanCount + 1'b1;
            if (showStrobe) begin
                pendNegative <= showNegative;
                pendDecimal  <= showDecimal;
            end
            if (convDone) begin
                shown   <= '{conv0, conv1, conv2, conv3};
                negHeld <= pendNegative;
                decHeld <= pendDecimal;
            end
        end
    end

    assign scanSel = scanCount[`SCAN_BITS +: 2]; // digit 0, 1, 2, 3 in turn
    assign anode   = ~(4'b0001 << scanSel);

    always_comb begin
        segment = digitToSeg(shown[scanSel]);
        if (scanSel == 2'd3 && negHeld) begin
            segment = `SEG_DASH;
        end
        if (scanSel == 2'd2 && decHeld) begin
            segment = segment & `SEG_DP_MASK; // point after the dollars
        end
    end

endmodule

// File: source/bcdConvert.sv
`timescale 1ns/10ps

module bcdConvert (
    input  logic                 A1,        // clock
    input  logic                 A2,        // async reset, active high
    input  logic                 startConv, // restarts a running conversion
    input  vendingPkg::centsT    binValue,
    output logic                 convDone,  // pulse, 11 cycles after start
    output vendingPkg::bcdDigitT digit0,    // ones
    output vendingPkg::bcdDigitT digit1,
    output vendingPkg::bcdDigitT digit2,
    output vendingPkg::bcdDigitT digit3     // thousands
);
    import vendingPkg::*;

    convStateE   state;
    logic [3:0]  shiftCount;
    centsT       binShift;  // binary bits still to shift in, msb first
    logic [15:0] bcd;       // four packed digits
    logic [15:0] bcdAdj;

    // add 3 to every digit of 5 or more ahead of the shift
    always_comb begin
        for (int n = 0; n < 4; n++) begin
            bcdAdj[4*n +: 4] = (bcd[4*n +: 4] >= 4'd5) ? bcd[4*n +: 4] + 4'd3
                                                       : bcd[4*n +: 4];
        end
    end

    always_ff @(posedge A1 or posedge A2) begin
        if (A2) begin
            state      <= convIdle;
            shiftCount <= '0;
            convDone   <= 1'b0;
        end else begin
            convDone <= 1'b0;
            if (startConv) begin
                state      <= convShift; // load cycle
                shiftCount <= '0;
            end else if (state == convShift) begin
                shiftCount <= shiftCount + 4'd1;
                if (shiftCount == 4'd9) begin // tenth shift
                    state    <= convIdle;
                    convDone <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge A1) begin
        if (startConv) begin
            binShift <= binValue;
            bcd      <= '0;
        end else if (state == convShift) begin
            bcd      <= {bcdAdj[14:0], binShift[9]};
            binShift <= {binShift[8:0], 1'b0};
        end
    end

    assign digit0 = bcd[3:0];
    assign digit1 = bcd[7:4];
    assign digit2 = bcd[11:8];
    assign digit3 = bcd[15:12];

endmodule

// File: source/creditExecute.sv
`timescale 1ns/10ps
`include "vendingDefines.svh"

module creditExecute (
    input  logic                  A1,           // clock
    input  logic                  A2,           // async reset, active high
    input  logic                  cmdValid,
    input  vendingPkg::cmdKindE   cmdKind,
    input  vendingPkg::centsT     cmdCents,
    input  vendingPkg::itemIndexT cmdItem,
    output vendingPkg::itemMaskT  greenLed,
    output vendingPkg::itemMaskT  redLed,
    output vendingPkg::itemMaskT  dispensedLed,
    output logic                  showStrobe,   // new amount for the display
    output vendingPkg::centsT     showCents,
    output logic                  showNegative, // dash on the top digit
    output logic                  showDecimal
);
    import vendingPkg::*;

    localparam centsT PRICE [`ITEM_COUNT] = '{`PRICE_A1, `PRICE_A2, `PRICE_A3,
                                              `PRICE_B1, `PRICE_B2, `PRICE_B3,
                                              `PRICE_C1, `PRICE_C2, `PRICE_C3};

    centsT       credit;     // money inserted, only cancel lowers it
    centsT       change;     // change from the last purchase
    itemMaskT    selected;   // one-hot, last item bought
    centsT       showAmount; // shown value unless change is shown
    logic        showChange;
    centsT       price;
    logic [10:0] coinSum;    // one bit wider so the cap compare is exact

    assign price   = PRICE[cmdItem];
    assign coinSum = {1'b0, credit} + {1'b0, cmdCents};

    always_ff @(posedge A1 or posedge A2) begin
        if (A2) begin
            credit       <= '0;
            change       <= '0;
            selected     <= '0;
            showAmount   <= '0;
            showChange   <= 1'b0;
            showStrobe   <= 1'b0;
            showNegative <= 1'b0;
            showDecimal  <= 1'b0;
        end else begin
            showStrobe <= 1'b0;
            if (cmdValid) begin
                case (cmdKind)
                    cmdCoin: begin
                        if (coinSum <= `MAX_CREDIT) begin // refused coin leaves all as is
                            credit       <= coinSum[9:0];
                            showAmount   <= coinSum[9:0];
                            showChange   <= 1'b0;
                            showNegative <= 1'b0;
                            showDecimal  <= 1'b1;
                            showStrobe   <= 1'b1;
                        end
                    end
                    vendingPkg::cmdItem: begin
                        showDecimal <= 1'b1;
                        showStrobe  <= 1'b1;
                        if (credit == '0) begin
                            showAmount   <= price;  // price check
                            showChange   <= 1'b0;
                            showNegative <= 1'b0;
                        end else if (credit >= price && price != '0) begin
                            change       <= credit - price; // buy
                            selected     <= itemMaskT'(1) << cmdItem;
                            showChange   <= 1'b1;
                            showNegative <= 1'b0;
                        end else begin
                            // shortfall, or zero for a sold-out item
                            showAmount   <= (price == '0) ? centsT'(0) : price - credit;
                            showChange   <= 1'b0;
                            showNegative <= 1'b1;
                        end
                    end
                    cmdCancel: begin
                        credit       <= '0;
                        change       <= '0;
                        selected     <= '0;
                        showAmount   <= '0;
                        showChange   <= 1'b0;
                        showNegative <= 1'b0;
                        showDecimal  <= 1'b0; // plain 0000
                        showStrobe   <= 1'b1;
                    end
                    default: begin
                    end
                endcase
            end
        end
    end

    assign showCents = showChange ? change : showAmount;

    always_comb begin
        for (int i = 0; i < `ITEM_COUNT; i++) begin
            greenLed[i] = (credit >= PRICE[i]) && (PRICE[i] != '0);
            redLed[i]   = (PRICE[i] == '0); // sold out
        end
    end

    assign dispensedLed = selected;

endmodule

// File: source/keyDecode.sv
`timescale 1ns/10ps
`include "vendingDefines.svh"

module keyDecode (
    input  logic                  A1,        // clock
    input  logic                  A2,        // async reset, active high
    input  vendingPkg::itemMaskT  itemKey,
    input  vendingPkg::coinMaskT  coinKey,
    input  logic                  cancelKey,
    output logic                  cmdValid,  // one-cycle pulse
    output vendingPkg::cmdKindE   cmdKind,
    output vendingPkg::centsT     cmdCents,  // coin value, valid with cmdCoin
    output vendingPkg::itemIndexT cmdItem    // item number, valid with cmdItem
);
    import vendingPkg::*;

    localparam centsT COIN_VALUE [`COIN_COUNT] = '{`COIN_NICKEL, `COIN_DIME, `COIN_QUARTER,
                                                   `COIN_DOLLAR, `COIN_FIVE};

    itemMaskT  itemNow;
    itemMaskT  itemPrev;
    coinMaskT  coinNow;
    coinMaskT  coinPrev;
    logic      cancelNow;
    logic      cancelPrev;

    itemMaskT  itemEdge;
    coinMaskT  coinEdge;
    logic      cancelEdge;

    cmdKindE   nextKind;
    centsT     nextCents;
    itemIndexT nextItem;

    always_ff @(posedge A1 or posedge A2) begin
        if (A2) begin
            itemNow    <= '0;
            itemPrev   <= '0;
            coinNow    <= '0;
            coinPrev   <= '0;
            cancelNow  <= 1'b0;
            cancelPrev <= 1'b0;
        end else begin
            itemNow    <= itemKey;   // sample raw levels
            itemPrev   <= itemNow;
            coinNow    <= coinKey;
            coinPrev   <= coinNow;
            cancelNow  <= cancelKey;
            cancelPrev <= cancelNow;
        end
    end

    assign itemEdge   = itemNow & ~itemPrev; // rising edges only
    assign coinEdge   = coinNow & ~coinPrev;
    assign cancelEdge = cancelNow & ~cancelPrev;

    // coins beat items, items beat cancel, lowest index wins within a group
    always_comb begin
        nextKind  = cmdNone;
        nextCents = '0;
        nextItem  = '0;
        if (|coinEdge) begin
            nextKind = cmdCoin;
            for (int i = `COIN_COUNT - 1; i >= 0; i--) begin
                if (coinEdge[i]) begin
                    nextCents = COIN_VALUE[i]; // lower index overwrites
                end
            end
        end else if (|itemEdge) begin
            nextKind = vendingPkg::cmdItem; // port of the same name shadows the literal
            for (int i = `ITEM_COUNT - 1; i >= 0; i--) begin
                if (itemEdge[i]) begin
                    nextItem = itemIndexT'(i);
                end
            end
        end else if (cancelEdge) begin
            nextKind = cmdCancel;
        end
    end

    always_ff @(posedge A1 or posedge A2) begin
        if (A2) begin
            cmdValid <= 1'b0;
            cmdKind  <= cmdNone;
        end else begin
            cmdValid <= (nextKind != cmdNone);
            cmdKind  <= nextKind;
        end
    end

    always_ff @(posedge A1) begin
        cmdCents <= nextCents; // payload, qualified by cmdValid
        cmdItem  <= nextItem;
    end

endmodule

// File: source/vendingPkg.sv
package vendingPkg;

    typedef logic [9:0] centsT;     // money in cents, up to 1023
    typedef logic [8:0] itemMaskT;  // bit 0 = A1 ... bit 8 = C3
    typedef logic [4:0] coinMaskT;  // bit 0 = nickel ... bit 4 = five dollars
    typedef logic [3:0] itemIndexT; // item number 0..8
    typedef logic [3:0] bcdDigitT;  // one decimal digit
    typedef logic [7:0] segmentT;   // active-low segment pattern

    // command handed from key decode to credit logic
    typedef enum logic [1:0] {
        cmdNone   = 2'd0,
        cmdCoin   = 2'd1,
        cmdItem   = 2'd2,
        cmdCancel = 2'd3
    } cmdKindE;

    // binary to decimal converter
    typedef enum logic [0:0] {
        convIdle  = 1'b0,
        convShift = 1'b1
    } convStateE;

endpackage

// File: source/vendingDefines.svh
`ifndef VENDING_DEFINES_SVH
`define VENDING_DEFINES_SVH

// item prices in cents, a price of 0 marks the item sold out
`define PRICE_A1 10'd100
`define PRICE_A2 10'd0
`define PRICE_A3 10'd125
`define PRICE_B1 10'd175
`define PRICE_B2 10'd225
`define PRICE_B3 10'd250
`define PRICE_C1 10'd100
`define PRICE_C2 10'd325
`define PRICE_C3 10'd375

`define MAX_CREDIT   11'd500 // credit cap in cents

`define COIN_NICKEL  10'd5
`define COIN_DIME    10'd10
`define COIN_QUARTER 10'd25
`define COIN_DOLLAR  10'd100
`define COIN_FIVE    10'd500

`define ITEM_COUNT   9
`define COIN_COUNT   5

`define SCAN_BITS    2 // cycles per lit digit = 2**SCAN_BITS, raise for the board

// active-low segments, msb first, decimal point in bit 0
`define SEG_DIGIT_0  8'b1000_0001
`define SEG_DIGIT_1  8'b1111_0011
`define SEG_DIGIT_2  8'b0100_1001
`define SEG_DIGIT_3  8'b0110_0001
`define SEG_DIGIT_4  8'b0011_0011
`define SEG_DIGIT_5  8'b0010_0101
`define SEG_DIGIT_6  8'b0000_0101
`define SEG_DIGIT_7  8'b1111_0001
`define SEG_DIGIT_8  8'b0000_0001
`define SEG_DIGIT_9  8'b0010_0001
`define SEG_DASH     8'b0111_1111
`define SEG_DP_MASK  8'b1111_1110 // and-mask that lights the point

`endif
